// ==== crc_link_pkg.sv ====
/*
 The CRC must be exactly one link word wide, so CRC_WIDTH and DATA_WIDTH move together.
 Counters are plain wrapping vectors with no overflow flag.
*/
package crc_link_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // One payload word, which is also the size of the appended CRC beat
    localparam int DATA_WIDTH = 16;

    // CRC-16-CCITT, sized so that the CRC fits in one beat
    localparam int CRC_WIDTH = 16;

    // Width of the good and bad frame counters
    localparam int COUNT_WIDTH = 16;

    // A valid frame on the wire has at least one payload word and the CRC word
    localparam int MIN_FRAME_BEATS = 2;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [CRC_WIDTH-1:0] crc_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // Beat counter that only has to reach MIN_FRAME_BEATS before it saturates
    typedef logic [$clog2(MIN_FRAME_BEATS+1)-1:0] beat_cnt_t;

    // All ones start value, with no reflection and no final XOR
    localparam crc_t CRC_INIT = '1;

    // One beat on the link
    // Last marks the final payload word going into the framer
    // and the CRC word coming out of it
    typedef struct packed {
        logic  valid;
        logic  last;
        word_t data;
    } link_beat_t;

endpackage

// ==== crc.sv ====
/*
 Bit-serial MSB-first CRC over one DATA_WIDTH word per cycle, all-ones start value.
 Only CRC_WIDTH of 8, 16, 32 or 64 is supported; other widths stop elaboration.
*/
`timescale 1ns/1ps

module crc #(
    parameter int DATA_WIDTH = 16,
    parameter int CRC_WIDTH  = 16
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  init_i,
    input  logic                  en_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    output logic [ CRC_WIDTH-1:0] crc_o
);

    // Start point of this cycle's update
    // A word that comes with init_i is folded into a fresh all-ones value
    logic [CRC_WIDTH-1:0] crc_base;

    if ((CRC_WIDTH != 8) && (CRC_WIDTH != 16) && (CRC_WIDTH != 32) &&
        (CRC_WIDTH != 64)) begin : g_width_check
        $error("crc supports CRC_WIDTH of 8, 16, 32 or 64 only");
    end

    ////////////////////
    // Polynomial and update functions
    ////////////////////

    // Generator polynomial without its top term, picked by CRC_WIDTH
    function automatic logic [CRC_WIDTH-1:0] crc_poly();
        logic [63:0] poly;
        case (CRC_WIDTH)
            // CRC-8-CCITT, x^8 + x^2 + x + 1
            8:       poly = 64'h07;
            // CRC-16-CCITT, x^16 + x^12 + x^5 + 1
            16:      poly = 64'h1021;
            // CRC-32-MPEG-2
            32:      poly = 64'h04c1_1db7;
            // CRC-64-ISO, x^64 + x^4 + x^3 + x + 1
            64:      poly = 64'h1b;
            default: poly = '0;
        endcase
        return poly[CRC_WIDTH-1:0];
    endfunction

    // One shift of the LFSR
    // The incoming bit is XORed into the MSB before the feedback decision
    function automatic logic [CRC_WIDTH-1:0] crc_bit(
        input logic [CRC_WIDTH-1:0] crc,
        input logic                 data
    );
        logic                 feedback;
        logic [CRC_WIDTH-1:0] next;
        feedback = crc[CRC_WIDTH-1] ^ data;
        next     = crc << 1;
        if (feedback) begin
            next = next ^ crc_poly();
        end
        return next;
    endfunction

    // Whole word, most significant bit first
    function automatic logic [CRC_WIDTH-1:0] crc_word(
        input logic [CRC_WIDTH-1:0]  crc,
        input logic [DATA_WIDTH-1:0] data
    );
        logic [CRC_WIDTH-1:0] acc;
        acc = crc;
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            acc = crc_bit(acc, data[i]);
        end
        return acc;
    endfunction

    ////////////////////
    // CRC register
    ////////////////////

    always_comb begin
        crc_base = init_i ? '1 : crc_o;
    end

    // The register is the output, so a word enabled in one cycle
    // shows up in crc_o in the next
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            crc_o <= '1;
        end else if (en_i) begin
            crc_o <= crc_word(crc_base, data_i);
        end else if (init_i) begin
            crc_o <= '1;
        end
    end

endmodule

// ==== crc_framer.sv ====
/*
 No back-pressure. The sender must keep valid low for the cycle after each last word,
 because that cycle is the slot where the CRC beat goes out.
*/
`timescale 1ns/1ps

module crc_framer (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  crc_link_pkg::link_beat_t beat_i,
    output crc_link_pkg::link_beat_t beat_o
);

    import crc_link_pkg::*;

    logic  in_frame_q;
    logic  frame_start;
    logic  crc_slot_q;
    logic  out_valid_q;
    logic  out_last_q;
    word_t out_data_q;
    crc_t  crc_value;

    if (CRC_WIDTH != DATA_WIDTH) begin : g_width_check
        $error("crc_framer needs the CRC to fit exactly one link word");
    end

    // First valid word outside a frame restarts the CRC
    assign frame_start = beat_i.valid && !in_frame_q;

    crc #(
        .DATA_WIDTH(DATA_WIDTH),
        .CRC_WIDTH (CRC_WIDTH)
    ) crc_inst (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .init_i(frame_start),
        .en_i  (beat_i.valid),
        .data_i(beat_i.data),
        .crc_o (crc_value)
    );

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            in_frame_q  <= 1'b0;
            crc_slot_q  <= 1'b0;
            out_valid_q <= 1'b0;
            out_last_q  <= 1'b0;
        end else begin
            crc_slot_q  <= beat_i.valid && beat_i.last;
            out_valid_q <= beat_i.valid || crc_slot_q;
            out_last_q  <= crc_slot_q;
            if (beat_i.valid) begin
                in_frame_q <= !beat_i.last;
            end
        end
    end

    // In the slot cycle crc_value already holds the last payload word
    always_ff @(posedge clk_i) begin
        out_data_q <= crc_slot_q ? crc_value : beat_i.data;
    end

    always_comb begin
        beat_o.valid = out_valid_q;
        beat_o.last  = out_last_q;
        beat_o.data  = out_data_q;
    end

    // A word arriving in the slot would collide with the CRC beat
    a_no_valid_in_crc_slot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        beat_i.valid && beat_i.last |=> !beat_i.valid)
        else $error("crc_framer got a valid word in the CRC slot");

    a_last_has_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(beat_o.last) |-> beat_o.valid)
        else $error("crc_framer raised last without valid");

endmodule

// ==== crc_checker.sv ====
/*
 Expects the CRC as the last beat of each frame; bad frames are only reported.
 Good and bad totals take the verdict at the end of the frame_done_o cycle and wrap.
*/
`timescale 1ns/1ps

module crc_checker (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  crc_link_pkg::link_beat_t beat_i,
    output logic                     frame_done_o,
    output logic                     frame_ok_o,
    output crc_link_pkg::count_t     good_count_o,
    output crc_link_pkg::count_t     bad_count_o
);

    import crc_link_pkg::*;

    logic      in_frame_q;
    logic      frame_start;
    beat_cnt_t beat_cnt_q;
    logic      done_q;
    logic      residue_zero;
    logic      long_enough;
    count_t    good_q;
    count_t    bad_q;
    crc_t      residue;

    assign frame_start = beat_i.valid && !in_frame_q;

    // The received CRC word is run through the register like any payload word
    crc #(
        .DATA_WIDTH(DATA_WIDTH),
        .CRC_WIDTH (CRC_WIDTH)
    ) crc_inst (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .init_i(frame_start),
        .en_i  (beat_i.valid),
        .data_i(beat_i.data),
        .crc_o (residue)
    );

    ////////////////////
    // Frame tracking
    ////////////////////

    // The beat count saturates, since only short frames matter here
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            in_frame_q <= 1'b0;
            beat_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= beat_i.valid && beat_i.last;
            if (beat_i.valid) begin
                in_frame_q <= !beat_i.last;
                if (frame_start) begin
                    beat_cnt_q <= beat_cnt_t'(1);
                end else if (beat_cnt_q != beat_cnt_t'(MIN_FRAME_BEATS)) begin
                    beat_cnt_q <= beat_cnt_q + beat_cnt_t'(1);
                end
            end
        end
    end

    ////////////////////
    // Verdict
    ////////////////////

    // One cycle after the last beat the register holds the residue of the whole frame
    assign residue_zero = (residue == '0);
    assign long_enough  = (beat_cnt_q == beat_cnt_t'(MIN_FRAME_BEATS));

    assign frame_done_o = done_q;
    assign frame_ok_o   = done_q && residue_zero && long_enough;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            good_q <= '0;
            bad_q  <= '0;
        end else if (done_q) begin
            if (residue_zero && long_enough) begin
                good_q <= good_q + count_t'(1);
            end else begin
                bad_q <= bad_q + count_t'(1);
            end
        end
    end

    assign good_count_o = good_q;
    assign bad_count_o  = bad_q;

    // Back-to-back verdicts mean two lasts in a row, so no frame had room for a CRC
    a_done_single_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        frame_done_o |=> !frame_done_o)
        else $error("crc_checker frame_done_o held for two cycles");

endmodule

// ==== crc_link_top.sv ====
/*
 The transmit output and receive input are separate ports, so any loopback
 or error injection lives outside this block.
*/
`timescale 1ns/1ps

module crc_link_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  crc_link_pkg::link_beat_t tx_beat_i,
    output crc_link_pkg::link_beat_t tx_beat_o,
    input  crc_link_pkg::link_beat_t rx_beat_i,
    output logic                     frame_done_o,
    output logic                     frame_ok_o,
    output crc_link_pkg::count_t     good_count_o,
    output crc_link_pkg::count_t     bad_count_o
);

    ////////////////////
    // Transmit side
    ////////////////////

    // Payload goes out one cycle late, with the CRC beat one cycle after the last word
    crc_framer crc_framer_inst (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .beat_i(tx_beat_i),
        .beat_o(tx_beat_o)
    );

    ////////////////////
    // Receive side
    ////////////////////

    // Verdict comes one cycle after the received CRC beat
    crc_checker crc_checker_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .beat_i      (rx_beat_i),
        .frame_done_o(frame_done_o),
        .frame_ok_o  (frame_ok_o),
        .good_count_o(good_count_o),
        .bad_count_o (bad_count_o)
    );

endmodule

// ==== tb_crc_model.svh ====
/*
 Reference CRC and frame helpers for the testbench, included inside the testbench module.
 Needs crc_link_pkg imported before the include. Assumes CRC_WIDTH equals DATA_WIDTH.
*/
`ifndef TB_CRC_MODEL_SVH
`define TB_CRC_MODEL_SVH

typedef word_t word_queue_t[$];

// CRC-16-CCITT, all-ones start, no reflection, no final XOR
// Each word is XORed into the register and then shifted out one bit at a time
function automatic crc_t model_crc(input word_queue_t words);
    crc_t value;
    value = CRC_INIT;
    foreach (words[i]) begin
        value = value ^ words[i];
        repeat (CRC_WIDTH) begin
            if (value[CRC_WIDTH-1]) begin
                value = (value << 1) ^ crc_t'(16'h1021);
            end else begin
                value = value << 1;
            end
        end
    end
    return value;
endfunction

function automatic link_beat_t make_beat(input logic valid, input logic last, input word_t data);
    link_beat_t beat;
    beat.valid = valid;
    beat.last  = last;
    beat.data  = data;
    return beat;
endfunction

// Payload of len random words
function automatic word_queue_t random_frame(input int len);
    word_queue_t words;
    for (int i = 0; i < len; i++) begin
        words.push_back(word_t'($urandom));
    end
    return words;
endfunction

function automatic word_t bit_flip_mask(input int bit_idx);
    return word_t'(1) << bit_idx;
endfunction

`endif

// ==== tb_crc_link.sv ====
/*
 Loops the transmit beat back to the receive port and flips one data bit where a test asks.
 Stops at the first failed check.
*/
`timescale 1ns/1ps

module tb_crc_link;

    import crc_link_pkg::*;

    `include "tb_crc_model.svh"

    localparam int CLK_PERIOD_NS = 100;
    localparam int NUM_FRAMES    = 32;
    localparam int WATCHDOG_NS   = (NUM_FRAMES * 20 + 50) * CLK_PERIOD_NS;

    logic       clk_i = 1'b0;
    logic       rstn_i = 1'b0;
    link_beat_t tx_beat_i = '0;
    link_beat_t tx_beat_o;
    link_beat_t rx_beat_i;
    link_beat_t runt_beat = '0;
    logic       frame_done_o;
    logic       frame_ok_o;
    count_t     good_count_o;
    count_t     bad_count_o;

    crc_t   model_crc_q = '0;
    int     frame_id = 0;
    int     out_frame = 0;
    int     out_idx = 0;
    int     flip_frame_next = -1;
    int     flip_beat_next = -1;
    word_t  flip_mask_next = '0;
    int     flip_frame = -1;
    int     flip_beat_q = -1;
    word_t  flip_mask_q = '0;
    logic   verdict_q[$];
    int     clean_sent = 0;
    int     bad_sent = 0;

    crc_link_top crc_link_top_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .tx_beat_i   (tx_beat_i),
        .tx_beat_o   (tx_beat_o),
        .rx_beat_i   (rx_beat_i),
        .frame_done_o(frame_done_o),
        .frame_ok_o  (frame_ok_o),
        .good_count_o(good_count_o),
        .bad_count_o (bad_count_o)
    );

    always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping at the first failed check");
    endtask

    ////////////////////
    // Loopback
    ////////////////////

    // Position of the current beat on tx_beat_o, counted per frame
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            out_idx   <= 0;
            out_frame <= 0;
        end else if (tx_beat_o.valid) begin
            if (tx_beat_o.last) begin
                out_idx   <= 0;
                out_frame <= out_frame + 1;
            end else begin
                out_idx <= out_idx + 1;
            end
        end
    end

    // Flip settings of a frame take effect as its first beat reaches tx_beat_o
    // The frame before still needs the old ones for its CRC beat
    always @(posedge clk_i) begin
        flip_frame  <= flip_frame_next;
        flip_beat_q <= flip_beat_next;
        flip_mask_q <= flip_mask_next;
    end

    // A runt beat replaces the loopback while the framer is idle
    always_comb begin
        rx_beat_i = tx_beat_o;
        if (tx_beat_o.valid && out_frame == flip_frame && out_idx == flip_beat_q) begin
            rx_beat_i.data = tx_beat_o.data ^ flip_mask_q;
        end
        if (runt_beat.valid) begin
            rx_beat_i = runt_beat;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_pass_through: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $past(tx_beat_i.valid) |->
            tx_beat_o.valid && !tx_beat_o.last && tx_beat_o.data == $past(tx_beat_i.data))
        else stop_with_failure($sformatf("Error at %0t ns: payload beat not passed through, got %h",
            $time, tx_beat_o.data));

    a_crc_beat: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $past(tx_beat_i.valid && tx_beat_i.last, 2) |->
            tx_beat_o.valid && tx_beat_o.last && tx_beat_o.data == $past(model_crc_q, 2))
        else stop_with_failure($sformatf("Error at %0t ns: wrong CRC beat, got data %h",
            $time, tx_beat_o.data));

    a_tx_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$past(tx_beat_i.valid) && !$past(tx_beat_i.valid && tx_beat_i.last, 2) |->
            !tx_beat_o.valid)
        else stop_with_failure($sformatf("Error at %0t ns: transmit beat valid while idle", $time));

    a_good_count: assert property (@(posedge clk_i) disable iff (!rstn_i)
        good_count_o == $past(good_count_o) + count_t'($past(frame_done_o && frame_ok_o)))
        else stop_with_failure($sformatf("Error at %0t ns: good count is %0d",
            $time, good_count_o));

    a_bad_count: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bad_count_o == $past(bad_count_o) + count_t'($past(frame_done_o && !frame_ok_o)))
        else stop_with_failure($sformatf("Error at %0t ns: bad count is %0d",
            $time, bad_count_o));

    // Scoreboard of verdicts, in the order the frames were sent
    always @(negedge clk_i) begin
        if (rstn_i && frame_done_o) begin
            assert (verdict_q.size() > 0)
                else stop_with_failure("frame_done_o pulsed with no frame outstanding");
            assert (frame_ok_o == verdict_q[0])
                else stop_with_failure($sformatf("Error at %0t ns: frame_ok_o is %b, expected %b",
                    $time, frame_ok_o, verdict_q[0]));
            void'(verdict_q.pop_front());
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // flip_beat below zero sends the frame clean; flip_beat equal to the length hits the CRC
    task automatic send_frame(input word_queue_t words, input int flip_beat, input word_t mask);
        verdict_q.push_back(flip_beat < 0);
        if (flip_beat < 0) begin
            clean_sent++;
        end else begin
            bad_sent++;
        end
        for (int i = 0; i < words.size(); i++) begin
            @(posedge clk_i);
            if (i == 0) begin
                model_crc_q     <= model_crc(words);
                flip_frame_next <= frame_id;
                flip_beat_next  <= flip_beat;
                flip_mask_next  <= mask;
            end
            tx_beat_i <= make_beat(1'b1, i == words.size() - 1, words[i]);
        end
        @(posedge clk_i);
        tx_beat_i <= make_beat(1'b0, 1'b0, '0);
        frame_id++;
    endtask

    task automatic send_runt(input word_t data);
        verdict_q.push_back(1'b0);
        bad_sent++;
        @(posedge clk_i);
        runt_beat <= make_beat(1'b1, 1'b1, data);
        @(posedge clk_i);
        runt_beat <= make_beat(1'b0, 1'b0, '0);
    endtask

    task automatic wait_for_verdicts();
        while (verdict_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (2) @(posedge clk_i);
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("Timeout: the frames did not all complete in time");
    end

    initial begin
        int len;
        int beat;
        void'($urandom(32'hb46e_4270));
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        assert (!tx_beat_o.valid && !frame_done_o && good_count_o == '0 && bad_count_o == '0)
            else stop_with_failure($sformatf("Error at %0t ns: outputs not idle after reset",
                $time));

        // Shortest frame, then a short fixed one
        send_frame('{16'h1234}, -1, '0);
        send_frame('{16'h0000, 16'hffff, 16'ha5c3}, -1, '0);

        // Clean frames back to back with one idle cycle
        repeat (20) begin
            send_frame(random_frame($urandom_range(16, 1)), -1, '0);
        end

        // One flipped bit, alternating between payload and CRC beat
        for (int k = 0; k < 6; k++) begin
            len  = $urandom_range(16, 1);
            beat = (k % 2 == 0) ? $urandom_range(len - 1, 0) : len;
            send_frame(random_frame(len), beat, bit_flip_mask($urandom_range(15, 0)));
        end

        wait_for_verdicts();
        send_runt(word_t'($urandom));
        send_runt(16'h0000);
        wait_for_verdicts();

        send_frame(random_frame($urandom_range(16, 1)), -1, '0);
        send_frame(random_frame($urandom_range(16, 1)), -1, '0);
        wait_for_verdicts();

        @(negedge clk_i);
        assert (good_count_o == count_t'(clean_sent) && bad_count_o == count_t'(bad_sent))
            else stop_with_failure($sformatf("Error at %0t ns: totals %0d good %0d bad",
                $time, good_count_o, bad_count_o));
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
crc_link_pkg.sv
crc.sv
crc_framer.sv
crc_checker.sv
crc_link_top.sv
tb_crc_link.sv

// ==== Bender.yml ====
package:
  name: crc_link

sources:
  # Package first, then the RTL from the leaves up
  - crc_link_pkg.sv
  - crc.sv
  - crc_framer.sv
  - crc_checker.sv
  - crc_link_top.sv

  # Testbench, which includes tb_crc_model.svh from the project root
  - target: test
    include_dirs:
      - .
    files:
      - tb_crc_link.sv
